// File: logic/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Byte address as presented on the request port
`define CACHE_ADDR_W 48

// 64-byte blocks
`define CACHE_OFFSET_BITS 6

// Statistics counters wrap at this width
`define CACHE_COUNT_W 18

//////////////////////////////////////////////////////////////////////
// Level geometry
//////////////////////////////////////////////////////////////////////

// L1 has 4 sets of 2 ways
`define L1_SET_BITS 2
`define L1_WAYS 2

// L2 has 8 sets of 4 ways
`define L2_SET_BITS 3
`define L2_WAYS 4

// Opcode that marks a write access (ASCII 'W')
`define CACHE_OP_WRITE 8'h57

`endif

// File: logic/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

  // Full byte address
  typedef logic [`CACHE_ADDR_W-1:0] addr_t;

  // Address with the block offset stripped
  typedef logic [`CACHE_ADDR_W-`CACHE_OFFSET_BITS-1:0] block_addr_t;

  // Operation code of one access
  typedef logic [7:0] op_t;

  // One statistics counter
  typedef logic [`CACHE_COUNT_W-1:0] count_t;

  // Replacement choice for both levels
  typedef enum logic {
    POLICY_FIFO,
    POLICY_LRU
  } replace_policy_t;

  // Where the block was found
  typedef enum logic [1:0] {
    HIT_L1,
    HIT_L2,
    HIT_NONE
  } hit_level_t;

  // Lookup sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_L1,
    SEQ_L2,
    SEQ_RESP
  } seq_state_t;

endpackage

`default_nettype wire

// File: logic/tag_level.sv
`timescale 1ns/1ps
`default_nettype none

module tag_level import cache_pkg::*; #(
  parameter int SET_BITS = 2,
  parameter int WAYS     = 2
) (
  input  logic            clk,
  input  logic            reset,
  input  replace_policy_t policy,
  input  block_addr_t     block_addr,
  input  logic            commit,
  output logic            hit
);

  localparam int SETS  = 1 << SET_BITS;
  localparam int BLK_W = $bits(block_addr_t);
  localparam int TAG_W = BLK_W - SET_BITS;
  localparam int POS_W = (WAYS > 1) ? $clog2(WAYS) : 1;

  // Age-ordered tag store per set
  // Position 0 holds the newest entry, position WAYS-1 the oldest
  logic [TAG_W-1:0] tags  [SETS][WAYS];
  logic [WAYS-1:0]  valid [SETS];

  logic [SET_BITS-1:0] set_idx;
  logic [TAG_W-1:0]    tag;
  logic [WAYS-1:0]     way_hit;
  logic [POS_W-1:0]    hit_pos;
  logic [POS_W-1:0]    shift_last;
  logic                update;

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  // Low bits select the set, the rest is the tag
  assign set_idx = block_addr[SET_BITS-1:0];
  assign tag     = block_addr[BLK_W-1:SET_BITS];

  // Compare all ways of the addressed set in parallel
  always_comb begin
    way_hit = '0;
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid[set_idx][w] && (tags[set_idx][w] == tag);
    end
  end

  assign hit = |way_hit;

  // Position of the matching entry
  // At most one way can match, lowest index wins anyway
  always_comb begin
    hit_pos = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_pos = POS_W'(w);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Age list update
  //////////////////////////////////////////////////////////////////////

  // Miss shifts the whole list and drops the oldest
  // LRU hit shifts only the entries younger than the hit one
  assign shift_last = hit ? hit_pos : POS_W'(WAYS - 1);

  // FIFO hit leaves the list as it is
  assign update = commit && !(hit && (policy == POLICY_FIFO));

  // Valid bits stay packed from position 0 upward
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < SETS; s++) begin
        valid[s] <= '0;
      end
    end else if (update) begin
      for (int w = 1; w < WAYS; w++) begin
        if (w <= int'(shift_last)) begin
          valid[set_idx][w] <= valid[set_idx][w-1];
        end
      end
      valid[set_idx][0] <= 1'b1;
    end
  end

  // Tag payload moves with its valid bit
  always_ff @(posedge clk) begin
    if (update) begin
      for (int w = 1; w < WAYS; w++) begin
        if (w <= int'(shift_last)) begin
          tags[set_idx][w] <= tags[set_idx][w-1];
        end
      end
      // New or promoted tag becomes the newest entry
      tags[set_idx][0] <= tag;
    end
  end

endmodule

`default_nettype wire

// File: logic/access_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module access_sequencer import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  // Request port
  input  logic        req_valid,
  output logic        req_ready,
  input  addr_t       req_addr,
  input  op_t         req_op,
  // Response port
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output hit_level_t  rsp_level,
  // Tag level control
  output block_addr_t block_addr,
  input  logic        l1_hit,
  input  logic        l2_hit,
  output logic        l1_commit,
  output logic        l2_commit,
  // Statistics outcome
  output logic        outcome_strobe,
  output hit_level_t  outcome_level,
  output logic        outcome_write
);

  seq_state_t state;
  seq_state_t state_next;
  logic       write_q;
  hit_level_t level_q;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      SEQ_IDLE: begin
        if (req_valid) begin
          state_next = SEQ_L1;
        end
      end
      // L1 hit finishes here, a miss goes on to L2
      SEQ_L1:   state_next = l1_hit ? SEQ_RESP : SEQ_L2;
      SEQ_L2:   state_next = SEQ_RESP;
      // Hold the response until it is taken
      SEQ_RESP: begin
        if (rsp_ready) begin
          state_next = SEQ_IDLE;
        end
      end
      default:  state_next = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SEQ_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Capture block address and write flag on acceptance
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      block_addr <= req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_BITS];
      write_q    <= (req_op == `CACHE_OP_WRITE);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Level strobes and outcome
  //////////////////////////////////////////////////////////////////////

  // Each level updates in its own lookup cycle
  assign l1_commit = (state == SEQ_L1);
  assign l2_commit = (state == SEQ_L2);

  // Pulse in the last lookup cycle
  assign outcome_strobe = (state == SEQ_L1 && l1_hit) || (state == SEQ_L2);
  assign outcome_level  = (state == SEQ_L1) ? HIT_L1 : (l2_hit ? HIT_L2 : HIT_NONE);
  assign outcome_write  = write_q;

  // Result held for the whole response phase
  always_ff @(posedge clk) begin
    if (outcome_strobe) begin
      level_q <= outcome_level;
    end
  end

  assign req_ready = (state == SEQ_IDLE);
  assign rsp_valid = (state == SEQ_RESP);
  assign rsp_level = level_q;

endmodule

`default_nettype wire

// File: logic/access_counters.sv
`timescale 1ns/1ps
`default_nettype none

module access_counters import cache_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       outcome_strobe,
  input  hit_level_t outcome_level,
  input  logic       outcome_write,
  output count_t     l1_hits,
  output count_t     l1_misses,
  output count_t     l2_hits,
  output count_t     l2_misses,
  output count_t     writes
);

  //////////////////////////////////////////////////////////////////////
  // Statistics, one update per finished lookup
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      l1_hits   <= '0;
      l1_misses <= '0;
      l2_hits   <= '0;
      l2_misses <= '0;
      writes    <= '0;
    end else if (outcome_strobe) begin
      case (outcome_level)
        HIT_L1: l1_hits <= l1_hits + count_t'(1);
        // L2 is only consulted after an L1 miss
        HIT_L2: begin
          l1_misses <= l1_misses + count_t'(1);
          l2_hits   <= l2_hits + count_t'(1);
        end
        HIT_NONE: begin
          l1_misses <= l1_misses + count_t'(1);
          l2_misses <= l2_misses + count_t'(1);
        end
        default: ;
      endcase
      // Writes counted on top of the level outcome
      if (outcome_write) begin
        writes <= writes + count_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/cache_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_engine import cache_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  replace_policy_t replace_policy,
  input  logic            req_valid,
  output logic            req_ready,
  input  addr_t           req_addr,
  input  op_t             req_op,
  output logic            rsp_valid,
  input  logic            rsp_ready,
  output hit_level_t      rsp_level,
  output count_t          l1_hits,
  output count_t          l1_misses,
  output count_t          l2_hits,
  output count_t          l2_misses,
  output count_t          writes
);

  // Shared block address and per level strobes
  block_addr_t block_addr;
  logic        l1_hit;
  logic        l2_hit;
  logic        l1_commit;
  logic        l2_commit;
  // Outcome to the statistics block
  logic        outcome_strobe;
  hit_level_t  outcome_level;
  logic        outcome_write;

  //////////////////////////////////////////////////////////////////////
  // Sequencer and two tag levels
  //////////////////////////////////////////////////////////////////////

  access_sequencer u_sequencer (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_addr       (req_addr),
    .req_op         (req_op),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .rsp_level      (rsp_level),
    .block_addr     (block_addr),
    .l1_hit         (l1_hit),
    .l2_hit         (l2_hit),
    .l1_commit      (l1_commit),
    .l2_commit      (l2_commit),
    .outcome_strobe (outcome_strobe),
    .outcome_level  (outcome_level),
    .outcome_write  (outcome_write)
  );

  // Small L1
  tag_level #(
    .SET_BITS (`L1_SET_BITS),
    .WAYS     (`L1_WAYS)
  ) l1_level (
    .clk        (clk),
    .reset      (reset),
    .policy     (replace_policy),
    .block_addr (block_addr),
    .commit     (l1_commit),
    .hit        (l1_hit)
  );

  // Larger L2, same lookup address
  tag_level #(
    .SET_BITS (`L2_SET_BITS),
    .WAYS     (`L2_WAYS)
  ) l2_level (
    .clk        (clk),
    .reset      (reset),
    .policy     (replace_policy),
    .block_addr (block_addr),
    .commit     (l2_commit),
    .hit        (l2_hit)
  );

  access_counters u_counters (
    .clk            (clk),
    .reset          (reset),
    .outcome_strobe (outcome_strobe),
    .outcome_level  (outcome_level),
    .outcome_write  (outcome_write),
    .l1_hits        (l1_hits),
    .l1_misses      (l1_misses),
    .l2_hits        (l2_hits),
    .l2_misses      (l2_misses),
    .writes         (writes)
  );

endmodule

`default_nettype wire

// File: bench/cache_engine_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cache_engine_chk import cache_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       req_valid,
  input logic       req_ready,
  input logic       rsp_valid,
  input logic       rsp_ready,
  input hit_level_t rsp_level,
  input count_t     l1_hits,
  input count_t     l1_misses,
  input count_t     l2_hits,
  input count_t     l2_misses,
  input count_t     writes
);

  //////////////////////////////////////////////////////////////////////
  // Handshake rules
  //////////////////////////////////////////////////////////////////////

  // Accepted request closes the request port with no response yet
  assert property (@(posedge clk) disable iff (reset)
    (req_valid && req_ready) |=> (!req_ready && !rsp_valid))
    else $error("accepted request did not move on to the lookup phase");

  // Stalled response holds valid and level
  assert property (@(posedge clk) disable iff (reset)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_level)))
    else $error("stalled response did not hold rsp_valid or rsp_level");

  // Statistics cleared by reset
  assert property (@(posedge clk) reset |=> (l1_hits == '0 && l1_misses == '0 &&
    l2_hits == '0 && l2_misses == '0 && writes == '0))
    else $error("counters not zero one cycle after reset");

endmodule

bind cache_engine cache_engine_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp_level (rsp_level),
  .l1_hits   (l1_hits),
  .l1_misses (l1_misses),
  .l2_hits   (l2_hits),
  .l2_misses (l2_misses),
  .writes    (writes)
);

`default_nettype wire

// File: bench/cache_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_engine_tb import cache_pkg::*; ;

  logic            clk;
  logic            reset;
  replace_policy_t replace_policy;
  logic            req_valid;
  logic            req_ready;
  addr_t           req_addr;
  op_t             req_op;
  logic            rsp_valid;
  logic            rsp_ready;
  hit_level_t      rsp_level;
  count_t          l1_hits;
  count_t          l1_misses;
  count_t          l2_hits;
  count_t          l2_misses;
  count_t          writes;

  // Reference age lists, index 0 is L1 and 1 is L2, full block kept as tag
  block_addr_t model_tag [2][8][4];
  bit          model_val [2][8][4];
  count_t      exp_l1_hits;
  count_t      exp_l1_misses;
  count_t      exp_l2_hits;
  count_t      exp_l2_misses;
  count_t      exp_writes;
  integer      seed = 32'heaa2_1fff;
  int          cycles = 0;

  cache_engine DUT (.*);

  always #10 clk = ~clk;

  // About 500 random plus a few dozen directed accesses at 3 to 4 cycles each
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 4000) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "Timeout: the run did not finish within 4000 cycles");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_level(input string name, input hit_level_t exp, input hit_level_t act);
    if (act !== exp) begin
      $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp) begin
      $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_counters();
    check_count("l1_hits", exp_l1_hits, l1_hits);
    check_count("l1_misses", exp_l1_misses, l1_misses);
    check_count("l2_hits", exp_l2_hits, l2_hits);
    check_count("l2_misses", exp_l2_misses, l2_misses);
    check_count("writes", exp_writes, writes);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Look up one level and apply the age list rule
  task automatic model_lookup(input int lvl, input block_addr_t blk, output bit hit);
    int ways;
    int set;
    int pos;
    if (lvl == 0) begin
      ways = `L1_WAYS;
      set  = int'(blk[`L1_SET_BITS-1:0]);
    end else begin
      ways = `L2_WAYS;
      set  = int'(blk[`L2_SET_BITS-1:0]);
    end
    hit = 1'b0;
    pos = ways - 1;
    for (int w = 0; w < ways; w++) begin
      if (model_val[lvl][set][w] && model_tag[lvl][set][w] == blk) begin
        hit = 1'b1;
        pos = w;
      end
    end
    // FIFO hit keeps the order, anything else shifts down to pos
    if (!(hit && replace_policy == POLICY_FIFO)) begin
      for (int w = pos; w > 0; w--) begin
        model_tag[lvl][set][w] = model_tag[lvl][set][w-1];
        model_val[lvl][set][w] = model_val[lvl][set][w-1];
      end
      model_tag[lvl][set][0] = blk;
      model_val[lvl][set][0] = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  task automatic apply_reset(input replace_policy_t policy);
    reset          = 1'b1;
    replace_policy = policy;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    foreach (model_val[l, s, w]) model_val[l][s][w] = 1'b0;
    exp_l1_hits   = '0;
    exp_l1_misses = '0;
    exp_l2_hits   = '0;
    exp_l2_misses = '0;
    exp_writes    = '0;
  endtask

  task automatic send_request(input addr_t addr, input op_t op);
    while (!req_ready) @(negedge clk);
    req_valid = 1'b1;
    req_addr  = addr;
    req_op    = op;
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Optional stall keeps rsp_ready low for some cycles after rsp_valid
  task automatic receive_response(input hit_level_t exp, input int stall,
                                  output hit_level_t got);
    while (!rsp_valid) @(negedge clk);
    got = rsp_level;
    check_level("rsp_level", exp, rsp_level);
    repeat (stall) begin
      @(negedge clk);
      check_flag("rsp_valid", 1'b1, rsp_valid);
      check_flag("req_ready", 1'b0, req_ready);
      check_level("rsp_level", exp, rsp_level);
    end
    rsp_ready = 1'b1;
    @(negedge clk);
  endtask

  // One full access checked against the model
  task automatic access(input addr_t addr, input op_t op, input int stall,
                        output hit_level_t got);
    block_addr_t blk;
    bit          h1;
    bit          h2;
    hit_level_t  exp;
    blk = addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_BITS];
    model_lookup(0, blk, h1);
    if (h1) begin
      exp         = HIT_L1;
      exp_l1_hits = exp_l1_hits + count_t'(1);
    end else begin
      model_lookup(1, blk, h2);
      exp           = h2 ? HIT_L2 : HIT_NONE;
      exp_l1_misses = exp_l1_misses + count_t'(1);
      if (h2) exp_l2_hits = exp_l2_hits + count_t'(1);
      else exp_l2_misses = exp_l2_misses + count_t'(1);
    end
    if (op == `CACHE_OP_WRITE) exp_writes = exp_writes + count_t'(1);
    if (stall > 0) rsp_ready = 1'b0;
    send_request(addr, op);
    receive_response(exp, stall, got);
  endtask

  function automatic addr_t blk_addr(input block_addr_t blk, input logic [5:0] off);
    return addr_t'({blk, off});
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    apply_reset(POLICY_LRU);
    check_flag("req_ready", 1'b1, req_ready);
    check_flag("rsp_valid", 1'b0, rsp_valid);
    check_counters();
  endtask

  task automatic test_repeat_block();
    hit_level_t got;
    apply_reset(POLICY_LRU);
    access(blk_addr(42'h48d15, 6'h00), 8'h52, 0, got);
    check_level("cold rsp_level", HIT_NONE, got);
    access(blk_addr(42'h48d15, 6'h00), 8'h52, 0, got);
    check_level("repeat rsp_level", HIT_L1, got);
    // Other byte in the same 64-byte block
    access(blk_addr(42'h48d15, 6'h2b), 8'h52, 0, got);
    check_level("same block rsp_level", HIT_L1, got);
    check_counters();
  endtask

  // A, B, A, C, A in L1 set 1
  task automatic test_policy_order(input replace_policy_t policy, input hit_level_t last);
    hit_level_t got;
    apply_reset(policy);
    access(blk_addr(42'h101, 6'h0), 8'h52, 0, got);
    access(blk_addr(42'h105, 6'h0), 8'h52, 0, got);
    access(blk_addr(42'h101, 6'h0), 8'h52, 0, got);
    access(blk_addr(42'h109, 6'h0), 8'h52, 0, got);
    access(blk_addr(42'h101, 6'h0), 8'h52, 0, got);
    check_level("final A rsp_level", last, got);
    check_counters();
  endtask

  task automatic test_l2_refill();
    hit_level_t got;
    apply_reset(POLICY_LRU);
    access(blk_addr(42'h202, 6'h0), 8'h52, 0, got);
    access(blk_addr(42'h206, 6'h0), 8'h52, 0, got);
    access(blk_addr(42'h20a, 6'h0), 8'h52, 0, got);
    access(blk_addr(42'h202, 6'h0), 8'h52, 0, got);
    check_level("evicted rsp_level", HIT_L2, got);
    access(blk_addr(42'h202, 6'h0), 8'h52, 0, got);
    check_level("refilled rsp_level", HIT_L1, got);
    check_counters();
  endtask

  task automatic test_stall_writes();
    hit_level_t got;
    op_t        ops [5];
    int         stall;
    ops = '{8'h57, 8'h52, 8'h57, 8'h41, 8'h57};
    apply_reset(POLICY_FIFO);
    for (int i = 0; i < 5; i++) begin
      stall = 1 + int'($unsigned($random(seed)) % 8);
      access(blk_addr(42'h330 + 42'(i % 3), 6'h4), ops[i], stall, got);
    end
    check_count("writes", count_t'(3), writes);
    check_counters();
  endtask

  // Pool of 20 blocks, 5 per used L2 set so L2 also evicts
  task automatic test_random_stream(input replace_policy_t policy);
    hit_level_t  got;
    int          idx;
    block_addr_t blk;
    logic [5:0]  off;
    op_t         op;
    apply_reset(policy);
    for (int n = 0; n < 250; n++) begin
      idx = int'($unsigned($random(seed)) % 20);
      blk = block_addr_t'(32'h300 + 2 * idx);
      off = 6'($random(seed));
      op  = ($random(seed) & 1) ? 8'h57 : 8'h52;
      access(blk_addr(blk, off), op, 0, got);
    end
    check_counters();
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    replace_policy = POLICY_FIFO;
    req_valid      = 1'b0;
    req_addr       = '0;
    req_op         = '0;
    rsp_ready      = 1'b1;
    test_reset_state();
    test_repeat_block();
    test_policy_order(POLICY_FIFO, HIT_L2);
    test_policy_order(POLICY_LRU, HIT_L1);
    test_l2_refill();
    test_stall_writes();
    test_random_stream(POLICY_FIFO);
    test_random_stream(POLICY_LRU);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: cache_engine.f
+incdir+logic
logic/cache_pkg.sv
logic/tag_level.sv
logic/access_sequencer.sv
logic/access_counters.sv
logic/cache_engine.sv
bench/cache_engine_chk.sv
bench/cache_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cache_engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f cache_engine.f \
  --top-module cache_engine_tb \
  -o cache_engine_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cache_engine_sim
if [ $? -ne 0 ]; then
  echo "Simulation returned a failing status"
  exit 1
fi

exit 0
